// File: Bender.yml
package:
  name: exec_core

sources:
  - exec_pkg.sv
  - issue_if.sv
  - retire_if.sv
  - reg_file.sv
  - inst_decode.sv
  - alu.sv
  - branch_unit.sv
  - execute.sv
  - result_stage.sv
  - exec_core_top.sv
  - target: simulation
    files:
      - tb_exec_core.sv

// File: alu.sv
`timescale 1ns/1ps

module alu import exec_pkg::*; (
    input  word_t    a,
    input  word_t    b,
    input  exec_op_t op,
    output word_t    y,
    output flags_t   flags
);

    always_comb begin
        case (op)
            OP_ADD,
            OP_ADDI: y = a + b;   // b is the immediate for addi
            OP_SUB:  y = a - b;
            OP_AND:  y = a & b;
            OP_OR:   y = a | b;
            OP_XOR:  y = a ^ b;
            OP_SHL:  y = a << b[4:0];
            OP_SHR:  y = a >> b[4:0];
            default: y = '0;      // result unused for other ops
        endcase
    end

    always_comb begin
        flags         = '0;
        flags[FLAG_Z] = (y == '0);
        flags[FLAG_N] = y[31];
    end

endmodule

// File: branch_unit.sv
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  exec_op_t op,
    input  flags_t   flags,
    input  word_t    pc,
    input  word_t    imm,
    input  word_t    ra_val,
    output word_t    next_pc,
    output logic     lr_wr,
    output word_t    lr_data
);

    word_t pc_4;
    word_t target;

    assign pc_4    = pc + 32'd4;
    assign target  = pc_4 + imm;
    assign lr_data = pc_4;   // return address for jal

    always_comb begin
        next_pc = pc_4;   // also covers illegal codes
        lr_wr   = 1'b0;
        case (op)
            OP_BEQ: next_pc = flags[FLAG_Z] ? target : pc_4;
            OP_BLT: next_pc = flags[FLAG_N] ? target : pc_4;
            OP_JMP: next_pc = ra_val;
            OP_JAL: begin
                next_pc = target;
                lr_wr   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: exec_core.f
exec_pkg.sv
issue_if.sv
retire_if.sv
reg_file.sv
inst_decode.sv
alu.sv
branch_unit.sv
execute.sv
result_stage.sv
exec_core_top.sv
tb_exec_core.sv

// File: exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top import exec_pkg::*; #(
    parameter int IN_CREDITS  = 2,
    parameter int OUT_CREDITS = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  inst_t    in_inst,
    input  word_t    in_pc,
    output logic     in_credit,
    output logic     res_valid,
    output word_t    res_pc,
    output word_t    res_next_pc,
    output reg_idx_t res_rd,
    output word_t    res_wdata,
    output logic     res_reg_wr,
    output flags_t   res_flags,
    output logic     res_illegal,
    input  logic     out_credit
);

    reg_idx_t rd_a_idx;
    reg_idx_t rd_b_idx;
    word_t    rd_a_data;
    word_t    rd_b_data;
    flags_t   rd_flags;
    word_t    rd_lr;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    logic     fl_wr;
    flags_t   fl_data;
    logic     lr_wr;
    word_t    lr_data;
    logic     fwd_valid;
    reg_idx_t fwd_rd;
    logic     fwd_reg_wr;
    word_t    fwd_wdata;
    logic     fwd_flag_wr;
    flags_t   fwd_flags;
    logic     fwd_lr_wr;
    word_t    fwd_lr;

    issue_if  u_iss ();
    retire_if u_ret ();

    inst_decode #(
        .IN_CREDITS  (IN_CREDITS),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_inst_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_inst    (in_inst),
        .in_pc      (in_pc),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .rd_a_idx   (rd_a_idx),
        .rd_b_idx   (rd_b_idx),
        .rd_a_data  (rd_a_data),
        .rd_b_data  (rd_b_data),
        .rd_flags   (rd_flags),
        .rd_lr      (rd_lr),
        .iss        (u_iss.decode)
    );

    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_a_idx  (rd_a_idx),
        .rd_b_idx  (rd_b_idx),
        .rd_a_data (rd_a_data),
        .rd_b_data (rd_b_data),
        .rd_flags  (rd_flags),
        .rd_lr     (rd_lr),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .fl_wr     (fl_wr),
        .fl_data   (fl_data),
        .lr_wr     (lr_wr),
        .lr_data   (lr_data)
    );

    execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .iss         (u_iss.execute),
        .ret         (u_ret.execute),
        .fwd_valid   (fwd_valid),
        .fwd_rd      (fwd_rd),
        .fwd_reg_wr  (fwd_reg_wr),
        .fwd_wdata   (fwd_wdata),
        .fwd_flag_wr (fwd_flag_wr),
        .fwd_flags   (fwd_flags),
        .fwd_lr_wr   (fwd_lr_wr),
        .fwd_lr      (fwd_lr)
    );

    result_stage u_result_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .ret         (u_ret.result),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .fl_wr       (fl_wr),
        .fl_data     (fl_data),
        .lr_wr       (lr_wr),
        .lr_data     (lr_data),
        .fwd_valid   (fwd_valid),
        .fwd_rd      (fwd_rd),
        .fwd_reg_wr  (fwd_reg_wr),
        .fwd_wdata   (fwd_wdata),
        .fwd_flag_wr (fwd_flag_wr),
        .fwd_flags   (fwd_flags),
        .fwd_lr_wr   (fwd_lr_wr),
        .fwd_lr      (fwd_lr),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_next_pc (res_next_pc),
        .res_rd      (res_rd),
        .res_wdata   (res_wdata),
        .res_reg_wr  (res_reg_wr),
        .res_flags   (res_flags),
        .res_illegal (res_illegal)
    );

endmodule

// File: exec_pkg.sv
package exec_pkg;

    localparam int NUM_REGS = 16;
    localparam int FLAG_Z   = 0;
    localparam int FLAG_N   = 1;

    typedef logic [31:0] word_t;     // data word, pc or immediate
    typedef logic [31:0] inst_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [14:0] imm_fld_t;  // raw immediate field before sign extension
    typedef logic [1:0]  flags_t;    // [1] n, [0] z

    typedef enum logic [4:0] {
        OP_ADD   = 5'd0,
        OP_SUB   = 5'd1,
        OP_AND   = 5'd2,
        OP_OR    = 5'd3,
        OP_XOR   = 5'd4,
        OP_SHL   = 5'd5,
        OP_SHR   = 5'd6,
        OP_ADDI  = 5'd7,
        OP_MOVLR = 5'd8,
        OP_BEQ   = 5'd9,
        OP_BLT   = 5'd10,
        OP_JMP   = 5'd11,
        OP_JAL   = 5'd12
    } exec_op_t;

    // one retired instruction as held by the result stage
    typedef struct packed {
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_wr;
        logic     flag_wr;
        flags_t   flags;
        logic     lr_wr;
        word_t    lr_data;
        logic     illegal;
    } retire_rec_t;

    function automatic logic is_alu_op(input exec_op_t op);
        return op inside {[OP_ADD:OP_ADDI]};
    endfunction

endpackage

// File: execute.sv
`timescale 1ns/1ps

module execute import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    issue_if.execute iss,
    retire_if.execute ret,
    input  logic     fwd_valid,
    input  reg_idx_t fwd_rd,
    input  logic     fwd_reg_wr,
    input  word_t    fwd_wdata,
    input  logic     fwd_flag_wr,
    input  flags_t   fwd_flags,
    input  logic     fwd_lr_wr,
    input  word_t    fwd_lr
);

    word_t  ra_val;
    word_t  rb_val;
    word_t  lr_val;
    word_t  op_b;
    word_t  alu_y;
    word_t  bu_next_pc;
    word_t  bu_lr_data;
    flags_t fl_val;
    flags_t alu_flags;
    logic   bu_lr_wr;
    logic   alu_op;
    logic   legal;

    // own result register is one ahead, result stage two ahead; newest wins
    always_comb begin
        ra_val = iss.ra_data;
        rb_val = iss.rb_data;
        fl_val = iss.flags;
        lr_val = iss.lr;
        if (fwd_valid && fwd_reg_wr && fwd_rd == iss.ra)
            ra_val = fwd_wdata;
        if (fwd_valid && fwd_reg_wr && fwd_rd == iss.rb)
            rb_val = fwd_wdata;
        if (fwd_valid && fwd_flag_wr)
            fl_val = fwd_flags;
        if (fwd_valid && fwd_lr_wr)
            lr_val = fwd_lr;
        if (ret.valid && ret.reg_wr && ret.rd == iss.ra)
            ra_val = ret.wdata;
        if (ret.valid && ret.reg_wr && ret.rd == iss.rb)
            rb_val = ret.wdata;
        if (ret.valid && ret.flag_wr)
            fl_val = ret.flags;
        if (ret.valid && ret.lr_wr)
            lr_val = ret.lr_data;
    end

    assign alu_op = is_alu_op(iss.op);
    assign legal  = iss.op inside {[OP_ADD:OP_JAL]};
    assign op_b   = (iss.op == OP_ADDI) ? iss.imm : rb_val;

    alu u_alu (
        .a     (ra_val),
        .b     (op_b),
        .op    (iss.op),
        .y     (alu_y),
        .flags (alu_flags)
    );

    branch_unit u_branch_unit (
        .op      (iss.op),
        .flags   (fl_val),
        .pc      (iss.pc),
        .imm     (iss.imm),
        .ra_val  (ra_val),
        .next_pc (bu_next_pc),
        .lr_wr   (bu_lr_wr),
        .lr_data (bu_lr_data)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            ret.valid <= 1'b0;
        else
            ret.valid <= iss.valid;
    end

    always_ff @(posedge clk) begin
        if (iss.valid) begin
            ret.pc      <= iss.pc;
            ret.next_pc <= bu_next_pc;
            ret.rd      <= iss.rd;
            ret.wdata   <= (iss.op == OP_MOVLR) ? lr_val : alu_y;
            ret.reg_wr  <= alu_op || (iss.op == OP_MOVLR);
            ret.flag_wr <= alu_op;
            ret.flags   <= alu_op ? alu_flags : fl_val;   // flag state after this op
            ret.lr_wr   <= bu_lr_wr;
            ret.lr_data <= bu_lr_data;
            ret.illegal <= !legal;
        end
    end

    a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        iss.valid |-> !$isunknown(iss.op));

endmodule

// File: inst_decode.sv
`timescale 1ns/1ps

module inst_decode import exec_pkg::*; #(
    parameter int IN_CREDITS  = 2,
    parameter int OUT_CREDITS = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  inst_t    in_inst,
    input  word_t    in_pc,
    input  logic     out_credit,
    output logic     in_credit,
    output reg_idx_t rd_a_idx,
    output reg_idx_t rd_b_idx,
    input  word_t    rd_a_data,
    input  word_t    rd_b_data,
    input  flags_t   rd_flags,
    input  word_t    rd_lr,
    issue_if.decode  iss
);

    localparam int PTR_W  = (IN_CREDITS > 1) ? $clog2(IN_CREDITS) : 1;
    localparam int QCNT_W = $clog2(IN_CREDITS + 1);
    localparam int CRED_W = $clog2(OUT_CREDITS + 1);

    inst_t             q_inst [IN_CREDITS];
    word_t             q_pc   [IN_CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0] q_cnt;
    logic [CRED_W-1:0] cred_cnt;   // result records we may still produce
    logic              q_empty;
    logic              q_full;
    logic              issue;
    logic              push;
    logic              pop;
    inst_t             head_inst;
    word_t             head_pc;
    imm_fld_t          imm_fld;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(IN_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign q_empty = (q_cnt == '0);
    assign q_full  = (q_cnt == QCNT_W'(IN_CREDITS));

    // empty queue passes the arriving instruction straight to issue
    assign head_inst = q_empty ? in_inst : q_inst[rd_ptr];
    assign head_pc   = q_empty ? in_pc : q_pc[rd_ptr];
    assign issue     = (!q_empty || in_valid) && (cred_cnt != '0);
    assign push      = in_valid && !(q_empty && issue);
    assign pop       = issue && !q_empty;

    assign rd_a_idx = head_inst[22:19];
    assign rd_b_idx = head_inst[18:15];
    assign imm_fld  = head_inst[14:0];

    always_ff @(posedge clk) begin
        if (push) begin
            q_inst[wr_ptr] <= in_inst;
            q_pc[wr_ptr]   <= in_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            cred_cnt  <= CRED_W'(OUT_CREDITS);
            in_credit <= 1'b0;
            iss.valid <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            q_cnt     <= q_cnt + QCNT_W'(push) - QCNT_W'(pop);
            cred_cnt  <= cred_cnt - CRED_W'(issue) + CRED_W'(out_credit);
            in_credit <= issue;   // entry freed on issue
            iss.valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            iss.op      <= exec_op_t'(head_inst[31:27]);
            iss.rd      <= head_inst[26:23];
            iss.ra      <= rd_a_idx;
            iss.rb      <= rd_b_idx;
            iss.ra_data <= rd_a_data;
            iss.rb_data <= rd_b_data;
            iss.imm     <= {{17{imm_fld[14]}}, imm_fld};
            iss.pc      <= head_pc;
            iss.flags   <= rd_flags;
            iss.lr      <= rd_lr;
        end
    end

    // sender must not spend a credit it does not hold
    a_no_full_write: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !q_full);

    a_cred_limit: assert property (@(posedge clk) disable iff (!rst_n)
        cred_cnt <= CRED_W'(OUT_CREDITS));

    a_cred_return: assert property (@(posedge clk) disable iff (!rst_n)
        out_credit |-> (cred_cnt != CRED_W'(OUT_CREDITS)));

endmodule

// File: issue_if.sv
`timescale 1ns/1ps

interface issue_if import exec_pkg::*; ();

    logic     valid;
    exec_op_t op;
    reg_idx_t rd;
    reg_idx_t ra;
    reg_idx_t rb;
    word_t    ra_data;
    word_t    rb_data;
    word_t    imm;
    word_t    pc;
    flags_t   flags;   // as read from the register file
    word_t    lr;

    modport decode (
        output valid, op, rd, ra, rb, ra_data, rb_data, imm, pc, flags, lr
    );

    modport execute (
        input valid, op, rd, ra, rb, ra_data, rb_data, imm, pc, flags, lr
    );

endinterface

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_a_idx,
    input  reg_idx_t rd_b_idx,
    output word_t    rd_a_data,
    output word_t    rd_b_data,
    output flags_t   rd_flags,
    output word_t    rd_lr,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  logic     fl_wr,
    input  flags_t   fl_data,
    input  logic     lr_wr,
    input  word_t    lr_data
);

    word_t  regs [NUM_REGS];
    flags_t flags_q;
    word_t  lr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            flags_q <= '0;
            lr_q    <= '0;
        end else begin
            if (wr_en)
                regs[wr_idx] <= wr_data;
            if (fl_wr)
                flags_q <= fl_data;
            if (lr_wr)
                lr_q <= lr_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd_a_data = (wr_en && wr_idx == rd_a_idx) ? wr_data : regs[rd_a_idx];
    assign rd_b_data = (wr_en && wr_idx == rd_b_idx) ? wr_data : regs[rd_b_idx];
    assign rd_flags  = fl_wr ? fl_data : flags_q;
    assign rd_lr     = lr_wr ? lr_data : lr_q;

endmodule

// File: result_stage.sv
`timescale 1ns/1ps

module result_stage import exec_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    retire_if.result ret,
    output logic     wr_en,
    output reg_idx_t wr_idx,
    output word_t    wr_data,
    output logic     fl_wr,
    output flags_t   fl_data,
    output logic     lr_wr,
    output word_t    lr_data,
    output logic     fwd_valid,
    output reg_idx_t fwd_rd,
    output logic     fwd_reg_wr,
    output word_t    fwd_wdata,
    output logic     fwd_flag_wr,
    output flags_t   fwd_flags,
    output logic     fwd_lr_wr,
    output word_t    fwd_lr,
    output logic     res_valid,
    output word_t    res_pc,
    output word_t    res_next_pc,
    output reg_idx_t res_rd,
    output word_t    res_wdata,
    output logic     res_reg_wr,
    output flags_t   res_flags,
    output logic     res_illegal
);

    retire_rec_t rec_q;
    logic        valid_q;

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= ret.valid;
    end

    always_ff @(posedge clk) begin
        if (ret.valid)
            rec_q <= '{ret.pc, ret.next_pc, ret.rd, ret.wdata, ret.reg_wr, ret.flag_wr,
                       ret.flags, ret.lr_wr, ret.lr_data, ret.illegal};
    end

    // register file write port qualified by the record valid
    assign wr_en   = valid_q && rec_q.reg_wr;
    assign wr_idx  = rec_q.rd;
    assign wr_data = rec_q.wdata;
    assign fl_wr   = valid_q && rec_q.flag_wr;
    assign fl_data = rec_q.flags;
    assign lr_wr   = valid_q && rec_q.lr_wr;
    assign lr_data = rec_q.lr_data;

    assign fwd_valid   = valid_q;
    assign fwd_rd      = rec_q.rd;
    assign fwd_reg_wr  = rec_q.reg_wr;
    assign fwd_wdata   = rec_q.wdata;
    assign fwd_flag_wr = rec_q.flag_wr;
    assign fwd_flags   = rec_q.flags;
    assign fwd_lr_wr   = rec_q.lr_wr;
    assign fwd_lr      = rec_q.lr_data;

    assign res_valid   = valid_q;
    assign res_pc      = rec_q.pc;
    assign res_next_pc = rec_q.next_pc;
    assign res_rd      = rec_q.rd;
    assign res_wdata   = rec_q.wdata;
    assign res_reg_wr  = rec_q.reg_wr;
    assign res_flags   = rec_q.flags;
    assign res_illegal = rec_q.illegal;

    a_no_illegal_wr: assert property (@(posedge clk) disable iff (!rst_n)
        ret.valid |-> !(ret.reg_wr && ret.illegal));

endmodule

// File: retire_if.sv
`timescale 1ns/1ps

interface retire_if import exec_pkg::*; ();

    logic     valid;
    word_t    pc;
    word_t    next_pc;
    reg_idx_t rd;
    word_t    wdata;
    logic     reg_wr;
    logic     flag_wr;
    flags_t   flags;
    logic     lr_wr;
    word_t    lr_data;
    logic     illegal;

    modport execute (
        output valid, pc, next_pc, rd, wdata, reg_wr, flag_wr, flags, lr_wr, lr_data, illegal
    );

    modport result (
        input valid, pc, next_pc, rd, wdata, reg_wr, flag_wr, flags, lr_wr, lr_data, illegal
    );

endinterface

// File: tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core import exec_pkg::*; ();

    localparam int IN_CREDITS  = 2;
    localparam int OUT_CREDITS = 4;
    localparam int CLK_PERIOD  = 20;

    typedef struct {
        inst_t inst;
        word_t pc;
        int    gap;   // idle cycles before this entry
    } stim_t;

    typedef struct {
        word_t    pc;
        word_t    next_pc;
        reg_idx_t rd;
        word_t    wdata;
        logic     reg_wr;
        flags_t   flags;
        logic     illegal;
    } expect_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    inst_t    in_inst;
    word_t    in_pc;
    logic     in_credit;
    logic     res_valid;
    word_t    res_pc;
    word_t    res_next_pc;
    reg_idx_t res_rd;
    word_t    res_wdata;
    logic     res_reg_wr;
    flags_t   res_flags;
    logic     res_illegal;
    logic     out_credit;

    stim_t   stim_q[$];
    expect_t exp_q[$];
    integer  seed = 32'hf652;
    int      send_credits = IN_CREDITS;   // sender side view of the input queue
    int      n_sent = 0;
    int      n_in_credit = 0;
    int      n_results = 0;
    int      n_returned = 0;
    int      owed = 0;                    // results seen but credit not yet returned
    logic    table_ready = 1'b0;

    exec_core_top #(
        .IN_CREDITS  (IN_CREDITS),
        .OUT_CREDITS (OUT_CREDITS)
    ) u_exec_core_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_pc       (in_pc),
        .in_credit   (in_credit),
        .res_valid   (res_valid),
        .res_pc      (res_pc),
        .res_next_pc (res_next_pc),
        .res_rd      (res_rd),
        .res_wdata   (res_wdata),
        .res_reg_wr  (res_reg_wr),
        .res_flags   (res_flags),
        .res_illegal (res_illegal),
        .out_credit  (out_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error at %0d ns: %s is %h, expected %h",
                                      $time, name, got, exp));
    endtask

    task automatic check_flags(input string name, input flags_t got, input flags_t exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error at %0d ns: %s is %b, expected %b",
                                      $time, name, got, exp));
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error at %0d ns: %s is %0d, expected %0d",
                                      $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_error($sformatf("** Error at %0d ns: %s is %b, expected %b",
                                      $time, name, got, exp));
    endtask

    function automatic inst_t encode(input logic [4:0] opc, input reg_idx_t rd,
                                     input reg_idx_t ra, input reg_idx_t rb, input int imm);
        inst_t w;
        w = {opc, rd, ra, rb, imm[14:0]};
        return w;
    endfunction

    task automatic add_entry(input logic [4:0] opc, input reg_idx_t rd, input reg_idx_t ra,
                             input reg_idx_t rb, input int imm, input int gap);
        stim_t s;
        s.inst = encode(opc, rd, ra, rb, imm);
        s.pc   = 32'h100 + 32'(4 * stim_q.size());
        s.gap  = gap;
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        logic [4:0] opc;
        reg_idx_t   rd_r;
        reg_idx_t   ra_r;
        reg_idx_t   rb_r;
        int         imm_r;
        int         gap_r;
        add_entry(OP_ADDI,  1,  0, 0, 5, 0);
        add_entry(OP_ADDI,  2,  0, 0, -3, 0);    // negative immediate
        add_entry(OP_ADD,   3,  1, 2, 0, 0);     // distance 2 and 1
        add_entry(OP_SUB,   4,  3, 1, 0, 0);
        add_entry(OP_AND,   5,  4, 1, 0, 1);
        add_entry(OP_OR,    6,  5, 2, 0, 0);
        add_entry(OP_XOR,   7,  6, 6, 0, 0);     // zero result
        add_entry(OP_SHL,   8,  1, 3, 0, 2);
        add_entry(OP_SHR,   9,  2, 1, 0, 0);
        add_entry(OP_SUB,  10,  1, 1, 0, 0);
        add_entry(OP_BEQ,   0,  0, 0, 8, 0);     // taken
        add_entry(OP_ADDI, 11,  0, 0, 1, 0);
        add_entry(OP_BEQ,   0,  0, 0, 8, 0);     // not taken
        add_entry(OP_SUB,  12,  0, 1, 0, 3);
        add_entry(OP_BLT,   0,  0, 0, -16, 0);   // taken
        add_entry(OP_ADD,  13,  1, 1, 0, 0);
        add_entry(OP_BLT,   0,  0, 0, -16, 0);   // not taken
        add_entry(OP_JMP,   0,  8, 0, 0, 1);
        add_entry(OP_JAL,   0,  0, 0, 'h40, 0);
        add_entry(OP_MOVLR, 14, 0, 0, 0, 0);
        add_entry(5'd20,   15, 1, 1, 7, 0);      // illegal code
        add_entry(OP_ADD,  15, 15, 14, 0, 0);
        add_entry(OP_MOVLR, 0, 0, 0, 0, 2);
        add_entry(OP_ADD,   0, 0, 1, 0, 0);      // r0 is ordinary
        add_entry(OP_ADD,   1, 0, 0, 0, 0);
        for (int i = 0; i < 10; i++) begin
            opc   = 5'({$random(seed)} % 8);
            rd_r  = reg_idx_t'({$random(seed)} % 5);
            ra_r  = reg_idx_t'({$random(seed)} % 5);
            rb_r  = reg_idx_t'({$random(seed)} % 5);
            imm_r = $random(seed);
            gap_r = {$random(seed)} % 3;
            add_entry(opc, rd_r, ra_r, rb_r, imm_r, gap_r);
        end
    endtask

    // sequential execution of the table in order
    task automatic run_model();
        word_t      mregs [NUM_REGS];
        flags_t     mflags;
        word_t      mlr;
        expect_t    e;
        logic [4:0] opc;
        reg_idx_t   ra;
        reg_idx_t   rb;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      y;
        word_t      pc4;
        foreach (mregs[i])
            mregs[i] = '0;
        mflags = '0;
        mlr    = '0;
        foreach (stim_q[i]) begin
            opc  = stim_q[i].inst[31:27];
            ra   = stim_q[i].inst[22:19];
            rb   = stim_q[i].inst[18:15];
            imm  = {{17{stim_q[i].inst[14]}}, stim_q[i].inst[14:0]};
            a    = mregs[ra];
            b    = (opc == OP_ADDI) ? imm : mregs[rb];
            pc4  = stim_q[i].pc + 32'd4;
            e.pc = stim_q[i].pc;
            e.rd = stim_q[i].inst[26:23];
            e.next_pc = pc4;
            e.wdata   = '0;
            e.reg_wr  = 1'b0;
            e.illegal = 1'b0;
            case (opc)
                OP_SUB:  y = a - b;
                OP_AND:  y = a & b;
                OP_OR:   y = a | b;
                OP_XOR:  y = a ^ b;
                OP_SHL:  y = a << b[4:0];
                OP_SHR:  y = a >> b[4:0];
                default: y = a + b;
            endcase
            if (opc <= 5'd7) begin
                mregs[e.rd] = y;
                mflags      = {y[31], y == '0};
                e.reg_wr    = 1'b1;
                e.wdata     = y;
            end else if (opc == OP_MOVLR) begin
                mregs[e.rd] = mlr;
                e.reg_wr    = 1'b1;
                e.wdata     = mlr;
            end else if (opc == OP_BEQ) begin
                if (mflags[0])
                    e.next_pc = pc4 + imm;
            end else if (opc == OP_BLT) begin
                if (mflags[1])
                    e.next_pc = pc4 + imm;
            end else if (opc == OP_JMP) begin
                e.next_pc = a;
            end else if (opc == OP_JAL) begin
                e.next_pc = pc4 + imm;
                mlr       = pc4;
            end else begin
                e.illegal = 1'b1;
            end
            e.flags = mflags;
            exp_q.push_back(e);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_inst    = '0;
        in_pc      = '0;
        out_credit = 1'b0;
        build_table();
        run_model();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("in_credit after reset", in_credit, 1'b0);
        check_bit("res_valid after reset", res_valid, 1'b0);
        foreach (stim_q[i]) begin
            repeat (stim_q[i].gap) begin
                @(posedge clk);
                #2;
            end
            while (send_credits == 0) begin   // wait for a freed queue entry
                @(posedge clk);
                #2;
            end
            in_valid = 1'b1;
            in_inst  = stim_q[i].inst;
            in_pc    = stim_q[i].pc;
            send_credits--;
            n_sent++;
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
        wait (n_results == stim_q.size());
        repeat (10) @(posedge clk);
        if (n_in_credit == n_sent) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_with_error("input credits were not all returned");
        end
    end

    // consumer with random phases of withheld credits
    initial begin
        int   phase_len;
        logic hold;
        phase_len = 0;
        hold      = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #2;
            if (phase_len == 0) begin
                hold      = 1'($random(seed));
                phase_len = 1 + {$random(seed)} % 12;
            end
            phase_len--;
            if (!hold && owed > 0) begin
                out_credit = 1'b1;
                owed--;
                n_returned++;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    // credit and result monitor on the falling edge
    initial begin
        expect_t e;
        forever begin
            @(negedge clk);
            if (rst_n && in_credit) begin
                send_credits++;
                n_in_credit++;
                if (send_credits > IN_CREDITS || n_in_credit > n_sent)
                    stop_with_error("in_credit returned more credits than were spent");
            end
            if (rst_n && res_valid) begin
                n_results++;
                owed++;
                if (n_results > OUT_CREDITS + n_returned)
                    stop_with_error("more results were produced than credits granted");
                if (exp_q.size() == 0)
                    stop_with_error("a result record arrived with none expected");
                e = exp_q.pop_front();
                check_word("res_pc", res_pc, e.pc);
                check_word("res_next_pc", res_next_pc, e.next_pc);
                check_idx("res_rd", res_rd, e.rd);
                check_bit("res_reg_wr", res_reg_wr, e.reg_wr);
                if (e.reg_wr)
                    check_word("res_wdata", res_wdata, e.wdata);
                check_flags("res_flags", res_flags, e.flags);
                check_bit("res_illegal", res_illegal, e.illegal);
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (stim_q.size() * 40 + 200) @(posedge clk);
        stop_with_error($sformatf("run timed out after %0d cycles", stim_q.size() * 40 + 200));
    end

endmodule
